// File: filelist.f
verilog/soc_ctrl_pkg.sv
verilog/pwr_rst_seq.sv
verilog/axi_user_straps.sv
verilog/mcu_trace_buffer.sv
verilog/soc_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/soc_ctrl_tb.sv

// File: Makefile
# Verilator simulation of the SoC power and reset control subsystem

TOP := soc_ctrl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/soc_ctrl_tb.sv
////////////////////////////////////////////////////////////////////////////
// SoC power and reset control testbench
// Runs a table of reset requests, strap updates and trace accesses against
// the top level and checks timing, strap latching and trace contents
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module soc_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PWRGOOD_DLY  = 5;
    localparam int RST_DLY      = 10;
    localparam int HALT_DLY     = 4;
    localparam int TRACE_DEPTH  = 256;
    localparam int PTR_W        = soc_ctrl_pkg::TRACE_PTR_W;
    localparam int RESET_CYCLES = 5;
    // Longest request sequence plus margin
    localparam int SEQ_WIN      = PWRGOOD_DLY + RST_DLY + HALT_DLY + 4;

    typedef enum logic [2:0] {OP_PWRUP, OP_REQ, OP_STRAP, OP_WRITE, OP_READ} op_e;

    // One table row, unused fields stay zero
    typedef struct packed {
        op_e                     op;
        soc_ctrl_pkg::rst_req_t  req;
        soc_ctrl_pkg::rst_done_t done;
        int                      halt;
        int                      pg;
        int                      rst;
        int                      addr;
        int                      n;
        logic [1:0]              vld;
        logic                    flag;
        int                      e_ptr;
        logic                    e_valid;
        logic                    e_wrap;
    } step_t;

    logic                           core_clk;
    logic                           reset_i;
    soc_ctrl_pkg::rst_req_t         rst_req_i;
    soc_ctrl_pkg::strap_in_t        straps_i;
    logic                           trace_vld_i;
    logic [31:0]                    trace_data_i;
    logic [PTR_W-1:0]               trace_rd_addr_i;
    logic                           pwrgood_o;
    logic                           core_rst_b_o;
    logic                           mcu_halt_o;
    soc_ctrl_pkg::rst_done_t        rst_done_o;
    soc_ctrl_pkg::axi_user_straps_t axi_user_o;
    logic [31:0]                    trace_rd_data_o;
    soc_ctrl_pkg::trace_status_t    trace_status_o;

    step_t                          steps[$];
    string                          labels[$];
    logic                           table_ready = 1'b0;
    int                             seed = 32'h7bcbdb46;
    int                             cur_step;
    int                             step_errs;
    // Reference copies of trace memory and latched straps
    logic [31:0]                    model_mem [TRACE_DEPTH];
    soc_ctrl_pkg::axi_user_straps_t exp_user;

    tb_clk_gen #(
        .HALF_PERIOD_NS (4),
        .RESET_CYCLES   (RESET_CYCLES)
    ) i_clk_gen (
        .core_clk_o (core_clk),
        .reset_o    (reset_i)
    );

    soc_ctrl_top #(
        .PWRGOOD_DLY (PWRGOOD_DLY),
        .RST_DLY     (RST_DLY),
        .HALT_DLY    (HALT_DLY),
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_dut (
        .core_clk        (core_clk),
        .reset_i         (reset_i),
        .rst_req_i       (rst_req_i),
        .pwrgood_o       (pwrgood_o),
        .core_rst_b_o    (core_rst_b_o),
        .mcu_halt_o      (mcu_halt_o),
        .rst_done_o      (rst_done_o),
        .straps_i        (straps_i),
        .axi_user_o      (axi_user_o),
        .trace_vld_i     (trace_vld_i),
        .trace_data_i    (trace_data_i),
        .trace_rd_addr_i (trace_rd_addr_i),
        .trace_rd_data_o (trace_rd_data_o),
        .trace_status_o  (trace_status_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Table rows
    ////////////////////////////////////////////////////////////////////////////

    // Cycle fields count rising edges after the launch edge, 0 means no change
    function automatic void seq_row(input string label, input op_e op, input logic [3:0] req,
                                    input logic [3:0] done, input int halt, input int pg,
                                    input int rst);
        step_t s;
        s      = '0;
        s.op   = op;
        s.req  = req;
        s.done = done;
        s.halt = halt;
        s.pg   = pg;
        s.rst  = rst;
        steps.push_back(s);
        labels.push_back(label);
    endfunction

    function automatic void write_row(input string label, input int addr, input int n,
                                      input logic acc, input int ptr, input logic valid,
                                      input logic wrapped);
        step_t s;
        s         = '0;
        s.op      = OP_WRITE;
        s.addr    = addr;
        s.n       = n;
        s.flag    = acc;
        s.e_ptr   = ptr;
        s.e_valid = valid;
        s.e_wrap  = wrapped;
        steps.push_back(s);
        labels.push_back(label);
    endfunction

    function automatic void read_row(input string label, input int addr, input int n);
        step_t s;
        s      = '0;
        s.op   = OP_READ;
        s.addr = addr;
        s.n    = n;
        steps.push_back(s);
        labels.push_back(label);
    endfunction

    // flag set means the latch should hold its old values
    function automatic void strap_row(input string label, input logic [1:0] vld,
                                      input logic hold);
        step_t s;
        s      = '0;
        s.op   = OP_STRAP;
        s.vld  = vld;
        s.flag = hold;
        steps.push_back(s);
        labels.push_back(label);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules and checks
    ////////////////////////////////////////////////////////////////////////////

    // SRAM config defaults to DMA, SoC config defaults to LSU
    function automatic soc_ctrl_pkg::axi_user_straps_t resolve_straps(
        input soc_ctrl_pkg::strap_in_t raw);
        soc_ctrl_pkg::axi_user_straps_t u;
        u.mcu_lsu      = raw.mcu_lsu;
        u.mcu_ifu      = raw.mcu_ifu;
        u.dma          = raw.dma;
        u.mcu_sram_cfg = raw.sram_cfg_vld ? raw.mcu_sram_cfg : raw.dma;
        u.mci_soc_cfg  = raw.soc_cfg_vld ? raw.mci_soc_cfg : raw.mcu_lsu;
        return u;
    endfunction

    function automatic soc_ctrl_pkg::strap_in_t random_straps(input logic [1:0] vld);
        soc_ctrl_pkg::strap_in_t raw;
        raw.mcu_lsu      = $random(seed);
        raw.mcu_ifu      = $random(seed);
        raw.mcu_sram_cfg = $random(seed);
        raw.mci_soc_cfg  = $random(seed);
        raw.dma          = $random(seed);
        raw.sram_cfg_vld = vld[1];
        raw.soc_cfg_vld  = vld[0];
        return raw;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: step %0d %s = 0x%0h, expected 0x%0h", cur_step, name, got, exp);
            step_errs++;
        end
    endtask

    // Watch outputs edge by edge, noting when each one first changes
    task automatic observe_sequence(input step_t s);
        int                      k;
        int                      pg_cyc;
        int                      rst_cyc;
        int                      halt_cnt;
        int                      done_cyc;
        logic                    pg_start;
        logic                    rst_start;
        soc_ctrl_pkg::rst_done_t done_bits;
        k         = 0;
        pg_cyc    = 0;
        rst_cyc   = 0;
        halt_cnt  = 0;
        done_cyc  = 0;
        done_bits = '0;
        pg_start  = pwrgood_o;
        rst_start = core_rst_b_o;
        // Power-up is launched by the reset release instead of a strobe
        if (s.op == OP_REQ) begin
            @(posedge core_clk);
            rst_req_i <= s.req;
        end
        while (k < SEQ_WIN && !(done_cyc != 0 && s.done != '0)) begin
            @(posedge core_clk);
            rst_req_i <= '0;
            @(negedge core_clk);
            k++;
            if (pg_cyc == 0 && pwrgood_o != pg_start) begin
                pg_cyc = k;
            end
            if (rst_cyc == 0 && core_rst_b_o != rst_start) begin
                rst_cyc = k;
            end
            if (mcu_halt_o) begin
                halt_cnt++;
            end
            if (rst_done_o != '0 && done_cyc == 0) begin
                done_cyc  = k;
                done_bits = rst_done_o;
            end
        end
        if (s.done != '0 && done_cyc == 0) begin
            $display("Step %0d: no done pulse within %0d cycles", cur_step, SEQ_WIN);
            step_errs++;
        end
        check_value("rst_done_o", 32'(done_bits), 32'(s.done));
        if (s.done != '0) begin
            check_value("rst_done_o cycle", done_cyc, s.rst);
        end
        check_value("mcu_halt_o cycles", halt_cnt, s.halt);
        check_value("pwrgood_o change cycle", pg_cyc, s.pg);
        check_value("core_rst_b_o change cycle", rst_cyc, s.rst);
    endtask

    task automatic apply_straps(input step_t s);
        soc_ctrl_pkg::strap_in_t raw;
        raw = random_straps(s.vld);
        @(posedge core_clk);
        straps_i <= raw;
        if (!s.flag) begin
            exp_user = resolve_straps(raw);
        end
        @(posedge core_clk);
        @(negedge core_clk);
        check_value("axi_user_o.mcu_lsu", axi_user_o.mcu_lsu, exp_user.mcu_lsu);
        check_value("axi_user_o.mcu_ifu", axi_user_o.mcu_ifu, exp_user.mcu_ifu);
        check_value("axi_user_o.mcu_sram_cfg", axi_user_o.mcu_sram_cfg, exp_user.mcu_sram_cfg);
        check_value("axi_user_o.mci_soc_cfg", axi_user_o.mci_soc_cfg, exp_user.mci_soc_cfg);
        check_value("axi_user_o.dma", axi_user_o.dma, exp_user.dma);
    endtask

    // Back-to-back writes, status checked the cycle after the last one
    task automatic write_trace(input step_t s);
        int          i;
        logic [31:0] data;
        for (i = 0; i < s.n; i++) begin
            @(posedge core_clk);
            data = $random(seed);
            trace_vld_i  <= 1'b1;
            trace_data_i <= data;
            if (s.flag) begin
                model_mem[(s.addr + i) % TRACE_DEPTH] = data;
            end
        end
        @(posedge core_clk);
        trace_vld_i <= 1'b0;
        @(negedge core_clk);
        check_value("trace_status_o.wr_ptr", 32'(trace_status_o.wr_ptr), s.e_ptr);
        check_value("trace_status_o.valid", 32'(trace_status_o.valid), 32'(s.e_valid));
        check_value("trace_status_o.wrapped", 32'(trace_status_o.wrapped), 32'(s.e_wrap));
    endtask

    task automatic read_trace(input step_t s);
        int i;
        for (i = 0; i < s.n; i++) begin
            @(posedge core_clk);
            trace_rd_addr_i <= PTR_W'((s.addr + i) % TRACE_DEPTH);
            @(posedge core_clk);
            @(negedge core_clk);
            check_value("trace_rd_data_o", trace_rd_data_o,
                        model_mem[(s.addr + i) % TRACE_DEPTH]);
        end
    endtask

    function automatic int run_budget();
        int total;
        total = RESET_CYCLES;
        foreach (steps[i]) begin
            total += SEQ_WIN + 2 * steps[i].n + 4;
        end
        return total;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        int i;
        int fail_cnt;
        int err_total;
        fail_cnt        = 0;
        err_total       = 0;
        rst_req_i       = '0;
        trace_vld_i     = 1'b0;
        trace_data_i    = '0;
        trace_rd_addr_i = '0;
        straps_i        = random_straps(2'b00);
        // Latch tracks the pins during the initial power-up
        exp_user        = resolve_straps(straps_i);

        seq_row("power-up after reset", OP_PWRUP, 4'b0000, 4'b0000, 0, PWRGOOD_DLY,
                PWRGOOD_DLY + RST_DLY);
        write_row("trace writes while running", 0, 5, 1'b1, 5, 1'b1, 1'b0);
        read_row("trace read back", 0, 5);
        seq_row("assert warm", OP_REQ, 4'b0010, 4'b0010, HALT_DLY, 0, HALT_DLY + 1);
        write_row("trace writes in warm reset", 5, 4, 1'b0, 5, 1'b1, 1'b0);
        seq_row("deassert warm", OP_REQ, 4'b0001, 4'b0001, 0, 0, RST_DLY);
        write_row("trace writes up to wrap", 5, TRACE_DEPTH + 3 - 5, 1'b1, 3, 1'b1, 1'b1);
        read_row("trace read after wrap", 0, 8);
        seq_row("assert hard", OP_REQ, 4'b1000, 4'b1000, HALT_DLY, HALT_DLY + 1,
                HALT_DLY + 1);
        write_row("trace cleared and ignored while off", 0, 3, 1'b0, 0, 1'b0, 1'b0);
        seq_row("deassert warm while off", OP_REQ, 4'b0001, 4'b0000, 0, 0, 0);
        strap_row("strap defaults", 2'b00, 1'b0);
        strap_row("strap overrides", 2'b11, 1'b0);
        seq_row("deassert hard", OP_REQ, 4'b0100, 4'b0100, 0, PWRGOOD_DLY,
                PWRGOOD_DLY + RST_DLY);
        strap_row("straps frozen at power-good", 2'b00, 1'b1);
        read_row("trace memory kept over power loss", 0, 3);
        write_row("trace restart after power-up", 0, 2, 1'b1, 2, 1'b1, 1'b0);
        read_row("trace read after restart", 0, 3);
        table_ready = 1'b1;

        for (i = 0; i < steps.size(); i++) begin
            cur_step  = i;
            step_errs = 0;
            case (steps[i].op)
                OP_PWRUP: begin
                    do begin
                        @(negedge core_clk);
                    end while (reset_i);
                    observe_sequence(steps[i]);
                end
                OP_REQ:   observe_sequence(steps[i]);
                OP_STRAP: apply_straps(steps[i]);
                OP_WRITE: write_trace(steps[i]);
                default:  read_trace(steps[i]);
            endcase
            if (step_errs == 0) begin
                $display("Step %0d %s: ok", i, labels[i]);
            end else begin
                $display("Step %0d %s: %0d errors", i, labels[i], step_errs);
                fail_cnt++;
            end
            err_total += step_errs;
        end

        $display("Steps %0d, failed %0d, errors %0d", steps.size(), fail_cnt, err_total);
        if (fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the table once it is built
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = run_budget();
        repeat (limit) @(posedge core_clk);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source
// Free-running core clock with a synchronous reset pulse at start-up
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 5
) (
    output logic core_clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        core_clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) core_clk_o = ~core_clk_o;
    end

    // Reset released on a rising edge, like any other driven input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge core_clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/soc_ctrl_top.sv
////////////////////////////////////////////////////////////////////////////
// SoC power and reset control top level
// Ties the power/reset sequencer to the strap latch and trace buffer
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module soc_ctrl_top #(
    parameter int PWRGOOD_DLY = 5,
    parameter int RST_DLY     = 10,
    parameter int HALT_DLY    = 4,
    parameter int TRACE_DEPTH = 256
) (
    input  logic                                 core_clk,
    input  logic                                 reset_i,

    // Reset control
    input  soc_ctrl_pkg::rst_req_t               rst_req_i,
    output logic                                 pwrgood_o,
    output logic                                 core_rst_b_o,
    output logic                                 mcu_halt_o,
    output soc_ctrl_pkg::rst_done_t              rst_done_o,

    // Straps
    input  soc_ctrl_pkg::strap_in_t              straps_i,
    output soc_ctrl_pkg::axi_user_straps_t       axi_user_o,

    // Trace
    input  logic                                 trace_vld_i,
    input  logic [31:0]                          trace_data_i,
    input  logic [soc_ctrl_pkg::TRACE_PTR_W-1:0] trace_rd_addr_i,
    output logic [31:0]                          trace_rd_data_o,
    output soc_ctrl_pkg::trace_status_t          trace_status_o
);

    // Depth must fill the pointer range exactly
    if (TRACE_DEPTH != (1 << soc_ctrl_pkg::TRACE_PTR_W)) begin : g_depth_chk
        $error("TRACE_DEPTH does not match TRACE_PTR_W");
    end

    // Rail and reset status shared with the other blocks
    logic pwrgood;
    logic core_rst_b;

    assign pwrgood_o    = pwrgood;
    assign core_rst_b_o = core_rst_b;

    pwr_rst_seq #(
        .PWRGOOD_DLY (PWRGOOD_DLY),
        .RST_DLY     (RST_DLY),
        .HALT_DLY    (HALT_DLY)
    ) i_pwr_rst_seq (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .rst_req_i    (rst_req_i),
        .pwrgood_o    (pwrgood),
        .core_rst_b_o (core_rst_b),
        .mcu_halt_o   (mcu_halt_o),
        .rst_done_o   (rst_done_o)
    );

    axi_user_straps i_axi_user_straps (
        .core_clk   (core_clk),
        .reset_i    (reset_i),
        .pwrgood_i  (pwrgood),
        .straps_i   (straps_i),
        .axi_user_o (axi_user_o)
    );

    mcu_trace_buffer #(
        .DEPTH (TRACE_DEPTH)
    ) i_mcu_trace_buffer (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .pwrgood_i    (pwrgood),
        .core_rst_b_i (core_rst_b),
        .trace_vld_i  (trace_vld_i),
        .trace_data_i (trace_data_i),
        .rd_addr_i    (trace_rd_addr_i),
        .rd_data_o    (trace_rd_data_o),
        .status_o     (trace_status_o)
    );

endmodule

`default_nettype wire

// File: verilog/mcu_trace_buffer.sv
////////////////////////////////////////////////////////////////////////////
// MCU trace buffer
// Circular store of 32-bit trace words taken while the core runs, with a
// wrapping write pointer, valid and wrap flags, and a registered read port
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module mcu_trace_buffer #(
    parameter int DEPTH = 256
) (
    input  logic                                 core_clk,
    input  logic                                 reset_i,
    input  logic                                 pwrgood_i,
    input  logic                                 core_rst_b_i,
    input  logic                                 trace_vld_i,
    input  logic [31:0]                          trace_data_i,
    input  logic [soc_ctrl_pkg::TRACE_PTR_W-1:0] rd_addr_i,
    output logic [31:0]                          rd_data_o,
    output soc_ctrl_pkg::trace_status_t          status_o
);

    localparam int PTR_W = soc_ctrl_pkg::TRACE_PTR_W;

    logic [31:0]                 mem_q [DEPTH];
    logic [31:0]                 rd_data_q;
    soc_ctrl_pkg::trace_status_t status_q;

    logic                        wr_en;
    logic                        last_entry;

    // Core in reset means nothing to record
    assign wr_en      = trace_vld_i & core_rst_b_i;
    assign last_entry = (status_q.wr_ptr == PTR_W'(DEPTH - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // Oldest entry simply gets overwritten after a wrap
    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem_q[status_q.wr_ptr] <= trace_data_i;
        end
    end

    // One-cycle read, sees writes from earlier cycles
    always_ff @(posedge core_clk) begin
        rd_data_q <= mem_q[rd_addr_i];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            status_q <= '0;
        end else if (!pwrgood_i) begin
            // Power loss drops the history, memory contents stay stale
            status_q <= '0;
        end else if (wr_en) begin
            status_q.valid <= 1'b1;
            if (last_entry) begin
                status_q.wr_ptr  <= '0;
                status_q.wrapped <= 1'b1;
            end else begin
                status_q.wr_ptr <= status_q.wr_ptr + 1'b1;
            end
        end
    end

    assign rd_data_o = rd_data_q;
    assign status_o  = status_q;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Pointer never runs past the configured depth
    a_ptr_in_range: assert property (@(posedge core_clk) disable iff (reset_i)
        {1'b0, status_q.wr_ptr} < (PTR_W + 1)'(DEPTH));

endmodule

`default_nettype wire

// File: verilog/axi_user_straps.sv
////////////////////////////////////////////////////////////////////////////
// AXI user strap latch
// Tracks the strap pins while power is down and freezes them at power-good,
// filling the SRAM-config and SoC-config users from DMA and LSU by default
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module axi_user_straps (
    input  logic                           core_clk,
    input  logic                           reset_i,
    input  logic                           pwrgood_i,
    input  soc_ctrl_pkg::strap_in_t        straps_i,
    output soc_ctrl_pkg::axi_user_straps_t axi_user_o
);

    soc_ctrl_pkg::axi_user_straps_t user_d;
    soc_ctrl_pkg::axi_user_straps_t user_q;

    ////////////////////////////////////////////////////////////////////////////
    // Default rules
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Straight copies
        user_d.mcu_lsu = straps_i.mcu_lsu;
        user_d.mcu_ifu = straps_i.mcu_ifu;
        user_d.dma     = straps_i.dma;

        // SRAM config follows the DMA user unless overridden
        user_d.mcu_sram_cfg = straps_i.sram_cfg_vld ? straps_i.mcu_sram_cfg
                                                    : straps_i.dma;

        // SoC config follows the LSU user unless overridden
        user_d.mci_soc_cfg  = straps_i.soc_cfg_vld ? straps_i.mci_soc_cfg
                                                   : straps_i.mcu_lsu;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Latch
    ////////////////////////////////////////////////////////////////////////////

    // Sample while rails are down, hold once power-good is up
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            user_q <= '0;
        end else if (!pwrgood_i) begin
            user_q <= user_d;
        end
    end

    assign axi_user_o = user_q;

endmodule

`default_nettype wire

// File: verilog/pwr_rst_seq.sv
////////////////////////////////////////////////////////////////////////////
// Power-good and core reset sequencer
// Brings up pwrgood then core reset after fixed delays, and serves the
// hard and warm reset strobes with a halt phase and one-cycle done pulses
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module pwr_rst_seq #(
    parameter int PWRGOOD_DLY = 5,
    parameter int RST_DLY     = 10,
    parameter int HALT_DLY    = 4
) (
    input  logic                    core_clk,
    input  logic                    reset_i,
    input  soc_ctrl_pkg::rst_req_t  rst_req_i,
    output logic                    pwrgood_o,
    output logic                    core_rst_b_o,
    output logic                    mcu_halt_o,
    output soc_ctrl_pkg::rst_done_t rst_done_o
);

    // Shared down-counter sized for the longest delay
    localparam int MAX_DLY = (PWRGOOD_DLY > RST_DLY) ?
                             ((PWRGOOD_DLY > HALT_DLY) ? PWRGOOD_DLY : HALT_DLY) :
                             ((RST_DLY > HALT_DLY) ? RST_DLY : HALT_DLY);
    localparam int CNT_W   = $clog2(MAX_DLY + 1);

    soc_ctrl_pkg::seq_state_e state_q;
    logic [CNT_W-1:0]         cnt_q;
    logic                     cnt_zero;

    // Pending request is a hard one (else warm)
    logic                     hard_q;
    // A deassert done is owed when the release completes
    logic                     pend_q;

    logic                     pwrgood_q;
    logic                     core_rst_b_q;
    logic                     halt_q;
    soc_ctrl_pkg::rst_done_t  done_q;

    assign cnt_zero = (cnt_q == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////////////////////////////////////////

    // Request taken at the end of cycle N acts from cycle N+1, so request
    // paths load DLY-2 where the power-up path loads DLY-1
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            // Power-up starts straight out of reset
            state_q      <= soc_ctrl_pkg::PWRGOOD_WAIT;
            cnt_q        <= CNT_W'(PWRGOOD_DLY - 1);
            hard_q       <= 1'b0;
            pend_q       <= 1'b0;
            pwrgood_q    <= 1'b0;
            core_rst_b_q <= 1'b0;
            halt_q       <= 1'b0;
            done_q       <= '0;
        end else begin
            // Done bits are single-cycle
            done_q <= '0;

            case (state_q)
                soc_ctrl_pkg::PWR_OFF: begin
                    // Only a hard release wakes the rails again
                    if (rst_req_i.deassert_hard) begin
                        state_q <= soc_ctrl_pkg::PWRGOOD_WAIT;
                        cnt_q   <= CNT_W'(PWRGOOD_DLY - 2);
                        hard_q  <= 1'b1;
                        pend_q  <= 1'b1;
                    end
                end

                soc_ctrl_pkg::PWRGOOD_WAIT: begin
                    if (cnt_zero) begin
                        pwrgood_q <= 1'b1;
                        state_q   <= soc_ctrl_pkg::RST_WAIT;
                        cnt_q     <= CNT_W'(RST_DLY - 1);
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end

                soc_ctrl_pkg::RST_WAIT: begin
                    if (cnt_zero) begin
                        core_rst_b_q <= 1'b1;
                        state_q      <= soc_ctrl_pkg::RUN;
                        pend_q       <= 1'b0;
                        // No reply for the initial power-up
                        if (pend_q) begin
                            done_q.deassert_hard <= hard_q;
                            done_q.deassert_warm <= ~hard_q;
                        end
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end

                soc_ctrl_pkg::RUN: begin
                    // Hard beats warm when both strobe together
                    if (rst_req_i.assert_hard || rst_req_i.assert_warm) begin
                        state_q <= soc_ctrl_pkg::HALT_WAIT;
                        halt_q  <= 1'b1;
                        cnt_q   <= CNT_W'(HALT_DLY - 1);
                        hard_q  <= rst_req_i.assert_hard;
                    end
                end

                soc_ctrl_pkg::HALT_WAIT: begin
                    if (cnt_zero) begin
                        // Halt done, core goes into reset
                        halt_q               <= 1'b0;
                        core_rst_b_q         <= 1'b0;
                        done_q.assert_hard   <= hard_q;
                        done_q.assert_warm   <= ~hard_q;
                        if (hard_q) begin
                            pwrgood_q <= 1'b0;
                            state_q   <= soc_ctrl_pkg::PWR_OFF;
                        end else begin
                            state_q <= soc_ctrl_pkg::WARM_RST;
                        end
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end

                soc_ctrl_pkg::WARM_RST: begin
                    // Escalation to hard reset still goes through a halt
                    if (rst_req_i.assert_hard) begin
                        state_q <= soc_ctrl_pkg::HALT_WAIT;
                        halt_q  <= 1'b1;
                        cnt_q   <= CNT_W'(HALT_DLY - 1);
                        hard_q  <= 1'b1;
                    end else if (rst_req_i.deassert_warm) begin
                        state_q <= soc_ctrl_pkg::RST_WAIT;
                        cnt_q   <= CNT_W'(RST_DLY - 2);
                        hard_q  <= 1'b0;
                        pend_q  <= 1'b1;
                    end
                end

                default: begin
                    state_q <= soc_ctrl_pkg::PWR_OFF;
                end
            endcase
        end
    end

    assign pwrgood_o    = pwrgood_q;
    assign core_rst_b_o = core_rst_b_q;
    assign mcu_halt_o   = halt_q;
    assign rst_done_o   = done_q;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Core must never leave reset on unpowered rails
    a_rst_b_needs_pwrgood: assert property (@(posedge core_clk) disable iff (reset_i)
        core_rst_b_o |-> pwrgood_o);

    // One reply per cycle at most
    a_done_onehot: assert property (@(posedge core_clk) disable iff (reset_i)
        $onehot0(rst_done_o));

endmodule

`default_nettype wire

// File: verilog/soc_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// SoC power and reset control types
// Request and done strobes, AXI user strap bundles, trace buffer status
// and the power/reset sequencer state encoding
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package soc_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Trace buffer sizing
    ////////////////////////////////////////////////////////////////////////////

    // Pointer width for the default 256-entry trace buffer
    localparam int TRACE_PTR_W = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Reset requests and replies
    ////////////////////////////////////////////////////////////////////////////

    // One-cycle request strobes from the test or system controller
    typedef struct packed {
        logic assert_hard;
        logic deassert_hard;
        logic assert_warm;
        logic deassert_warm;
    } rst_req_t;

    // One-cycle done pulses, same bit order as the requests
    typedef struct packed {
        logic assert_hard;
        logic deassert_hard;
        logic assert_warm;
        logic deassert_warm;
    } rst_done_t;

    ////////////////////////////////////////////////////////////////////////////
    // AXI user straps
    ////////////////////////////////////////////////////////////////////////////

    // Resolved user values as seen by the fabric
    typedef struct packed {
        logic [31:0] mcu_lsu;
        logic [31:0] mcu_ifu;
        logic [31:0] mcu_sram_cfg;
        logic [31:0] mci_soc_cfg;
        logic [31:0] dma;
    } axi_user_straps_t;

    // Raw strap pins, plus valid bits for the two overridable values
    typedef struct packed {
        logic [31:0] mcu_lsu;
        logic [31:0] mcu_ifu;
        logic [31:0] mcu_sram_cfg;
        logic [31:0] mci_soc_cfg;
        logic [31:0] dma;
        logic        sram_cfg_vld;
        logic        soc_cfg_vld;
    } strap_in_t;

    ////////////////////////////////////////////////////////////////////////////
    // Trace buffer status and sequencer states
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                   valid;
        logic                   wrapped;
        logic [TRACE_PTR_W-1:0] wr_ptr;
    } trace_status_t;

    typedef enum logic [2:0] {
        PWR_OFF,
        PWRGOOD_WAIT,
        RST_WAIT,
        RUN,
        HALT_WAIT,
        WARM_RST
    } seq_state_e;

endpackage

`default_nettype wire
